/* build.f */
+incdir+include
hw/fpu_pkg.sv
hw/fpu_op_if.sv
hw/exp_diff_exponent.sv
hw/shf_unit.sv
hw/alu_unit.sv
hw/fpu_normalize.sv
hw/fpu_32bit.sv
hw/fpu_apb_regs.sv
hw/fpu_apb_top.sv
sim/tb_fpu_apb.sv

/* hw/alu_unit.sv */
`timescale 1ns/1ns
`include "fpu_params.svh"

module alu_unit #(
    parameter int SIZE_DATA = `FPU_MAN_W + `FPU_GUARD_W + 1
) (
    input  fpu_pkg::fpu_op_e        i_op_alu,
    input  logic                    i_sign_a,       // Greater operand
    input  logic                    i_sign_b,       // Lesser operand
    input  logic [SIZE_DATA-1:0]    i_mantissa_a,   // Greater operand
    input  logic [SIZE_DATA-1:0]    i_mantissa_b,   // Lesser, already aligned

    output logic                    o_overflow,     // Carry out of the add
    output logic                    o_sign_result,
    output logic [SIZE_DATA-1:0]    o_mantissa_result
);

////////////////////////////////////////
// Effective sign of b
////////////////////////////////////////
logic w_sign_b_eff;
logic w_same_sign;

assign w_sign_b_eff = i_sign_b ^ (i_op_alu == fpu_pkg::FPU_SUB);  // Subtract flips b
assign w_same_sign  = (i_sign_a == w_sign_b_eff);

////////////////////////////////////////
// Magnitude add and subtract
////////////////////////////////////////
logic [SIZE_DATA:0] w_sum;      // Extra bit for carry
logic [SIZE_DATA:0] w_diff;     // Extra bit for borrow

assign w_sum  = {1'b0, i_mantissa_a} + {1'b0, i_mantissa_b};
assign w_diff = {1'b0, i_mantissa_a} - {1'b0, i_mantissa_b};

always_comb begin
    if (w_same_sign) begin
        o_overflow        = w_sum[SIZE_DATA];
        o_sign_result     = i_sign_a;
        o_mantissa_result = w_sum[SIZE_DATA-1:0];
    end else if (w_diff[SIZE_DATA]) begin
        // b was larger, flip magnitude and take b's sign
        o_overflow        = 1'b0;
        o_sign_result     = w_sign_b_eff;
        o_mantissa_result = i_mantissa_b - i_mantissa_a;
    end else begin
        o_overflow        = 1'b0;
        o_sign_result     = i_sign_a;
        o_mantissa_result = w_diff[SIZE_DATA-1:0];
    end
end

endmodule

/* hw/exp_diff_exponent.sv */
`timescale 1ns/1ns
`include "fpu_params.svh"

module exp_diff_exponent (
    input  logic [`FPU_EXP_W-1:0]   i_exp_a,
    input  logic [`FPU_EXP_W-1:0]   i_exp_b,

    output logic [`FPU_EXP_W-1:0]   o_exp_greater,
    output logic [`FPU_EXP_W-1:0]   o_diff_value,
    output logic                    o_diff_signal   // High when B is larger
);

////////////////////////////////////////
// Both differences with borrow
////////////////////////////////////////
logic [`FPU_EXP_W:0] w_diff_ab;    // a - b, MSB is borrow
logic [`FPU_EXP_W:0] w_diff_ba;    // b - a

assign w_diff_ab = {1'b0, i_exp_a} - {1'b0, i_exp_b};
assign w_diff_ba = {1'b0, i_exp_b} - {1'b0, i_exp_a};

// Borrow out of a - b means b > a
assign o_diff_signal = w_diff_ab[`FPU_EXP_W];

////////////////////////////////////////
// Select positive side
////////////////////////////////////////
assign o_diff_value  = o_diff_signal ? w_diff_ba[`FPU_EXP_W-1:0]
                                     : w_diff_ab[`FPU_EXP_W-1:0];
assign o_exp_greater = o_diff_signal ? i_exp_b : i_exp_a;   // Equal gives a

endmodule

/* hw/fpu_32bit.sv */
`timescale 1ns/1ns
`include "fpu_params.svh"

module fpu_32bit (
    input  logic    i_clk,
    input  logic    i_reset,
    fpu_op_if.core  io_op
);

localparam int MW = `FPU_MAN_W + 1;         // With hidden one
localparam int PW = MW + `FPU_GUARD_W;      // Mantissa path

////////////////////////////////////////
// Unpack and flush
////////////////////////////////////////
logic [MW-1:0] w_man_a, w_man_b;

assign w_man_a = (io_op.req_a.exp == '0) ? '0 : {1'b1, io_op.req_a.frac};
assign w_man_b = (io_op.req_b.exp == '0) ? '0 : {1'b1, io_op.req_b.frac};

logic [`FPU_EXP_W-1:0] w_exp_greater, w_diff_value;
logic                  w_diff_signal;

exp_diff_exponent u_exp_diff (
    .i_exp_a        (io_op.req_a.exp),
    .i_exp_b        (io_op.req_b.exp),
    .o_exp_greater  (w_exp_greater),
    .o_diff_value   (w_diff_value),
    .o_diff_signal  (w_diff_signal)
);

////////////////////////////////////////
// Order and align
////////////////////////////////////////
logic          w_swap, w_is_sub;
logic          w_sign_greater, w_sign_less;
logic [PW-1:0] w_man_greater, w_man_less, w_man_less_aligned;

// Equal exponents fall back to mantissa order
assign w_swap   = w_diff_signal || ((w_diff_value == '0) && (w_man_b > w_man_a));
assign w_is_sub = (io_op.req_op == fpu_pkg::FPU_SUB);

// ALU flips its b input on subtract, so pre-flip whichever side is A
assign w_sign_greater = w_swap ? (io_op.req_b.sign ^ w_is_sub) : io_op.req_a.sign;
assign w_sign_less    = w_swap ? (io_op.req_a.sign ^ w_is_sub) : io_op.req_b.sign;

assign w_man_greater = w_swap ? {w_man_b, {`FPU_GUARD_W{1'b0}}} : {w_man_a, {`FPU_GUARD_W{1'b0}}};
assign w_man_less    = w_swap ? {w_man_a, {`FPU_GUARD_W{1'b0}}} : {w_man_b, {`FPU_GUARD_W{1'b0}}};

shf_unit #(
    .LEFT_RIGHT (1),
    .SIZE_DATA  (PW),
    .SIZE_SHIFT (`FPU_EXP_W)    // Full difference, 28 and up clears
) u_shf_align (
    .i_shift_number (w_diff_value),
    .i_data         (w_man_less),
    .o_data         (w_man_less_aligned)
);

logic          w_alu_carry, w_alu_sign;
logic [PW-1:0] w_alu_mantissa;

alu_unit #(
    .SIZE_DATA (PW)
) u_alu (
    .i_op_alu           (io_op.req_op),
    .i_sign_a           (w_sign_greater),
    .i_sign_b           (w_sign_less),
    .i_mantissa_a       (w_man_greater),
    .i_mantissa_b       (w_man_less_aligned),
    .o_overflow         (w_alu_carry),
    .o_sign_result      (w_alu_sign),
    .o_mantissa_result  (w_alu_mantissa)
);

////////////////////////////////////////
// Stage 1 registers
////////////////////////////////////////
logic                  r_s1_valid;
logic                  r_s1_sign, r_s1_carry;
logic [`FPU_EXP_W-1:0] r_s1_exp;
logic [PW-1:0]         r_s1_mant;

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        r_s1_valid <= 1'b0;
    end else begin
        r_s1_valid <= io_op.req_valid;
    end
end

always_ff @(posedge i_clk) begin
    r_s1_sign  <= w_alu_sign;
    r_s1_carry <= w_alu_carry;
    r_s1_exp   <= w_exp_greater;   // Greater exponent leads
    r_s1_mant  <= w_alu_mantissa;
end

////////////////////////////////////////
// Stage 2 normalize
////////////////////////////////////////
fpu_pkg::fpu_float_s w_norm_result;
logic                w_norm_overflow;

fpu_normalize #(
    .SIZE_DATA (PW)
) u_normalize (
    .i_sign     (r_s1_sign),
    .i_carry    (r_s1_carry),
    .i_exp      (r_s1_exp),
    .i_mantissa (r_s1_mant),
    .o_result   (w_norm_result),
    .o_overflow (w_norm_overflow)
);

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        io_op.res_valid <= 1'b0;
    end else begin
        io_op.res_valid <= r_s1_valid;
    end
end

always_ff @(posedge i_clk) begin
    io_op.res_data     <= w_norm_result;
    io_op.res_overflow <= w_norm_overflow;
end

endmodule

/* hw/fpu_apb_regs.sv */
`timescale 1ns/1ns
`include "fpu_params.svh"

module fpu_apb_regs (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  logic [`FPU_ADDR_W-1:0]  i_paddr,
    input  logic [`FPU_DATA_W-1:0]  i_pwdata,

    output logic [`FPU_DATA_W-1:0]  o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,

    fpu_op_if.req                   io_op
);

////////////////////////////////////////
// Access decode
////////////////////////////////////////
logic w_access, w_wr_en;
logic w_ctrl_wr, w_start;
logic w_mapped;

assign w_access  = i_psel && i_penable;            // Access phase
assign w_wr_en   = w_access && i_pwrite;
assign w_ctrl_wr = w_wr_en && (i_paddr == `FPU_REG_CTRL);

// Registers
fpu_pkg::fpu_float_s    r_opa, r_opb, r_result;
fpu_pkg::fpu_op_e       r_op;
logic                   r_busy, r_done, r_overflow;

assign w_start = w_ctrl_wr && i_pwdata[1] && !r_busy;   // Start ignored while busy

////////////////////////////////////////
// Request to core
////////////////////////////////////////
assign io_op.req_valid = w_start;      // Same cycle as the access phase
assign io_op.req_op    = w_start ? fpu_pkg::fpu_op_e'(i_pwdata[0]) : r_op;
assign io_op.req_a     = r_opa;
assign io_op.req_b     = r_opb;

////////////////////////////////////////
// Operand and control writes
////////////////////////////////////////
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        r_opa <= '0;
        r_opb <= '0;
        r_op  <= fpu_pkg::FPU_ADD;
    end else begin
        if (w_wr_en && (i_paddr == `FPU_REG_OPA)) begin
            r_opa <= i_pwdata;
        end
        if (w_wr_en && (i_paddr == `FPU_REG_OPB)) begin
            r_opb <= i_pwdata;
        end
        if (w_ctrl_wr) begin
            r_op <= fpu_pkg::fpu_op_e'(i_pwdata[0]);   // Op bit stored on any CTRL write
        end
    end
end

////////////////////////////////////////
// Status and result
////////////////////////////////////////
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        r_busy     <= 1'b0;
        r_done     <= 1'b0;
        r_overflow <= 1'b0;
        r_result   <= '0;
    end else begin
        if (io_op.res_valid) begin
            r_busy     <= 1'b0;
            r_done     <= 1'b1;
            r_overflow <= io_op.res_overflow;
            r_result   <= io_op.res_data;
        end
        if (w_start) begin
            r_busy <= 1'b1;
            r_done <= 1'b0;     // New launch clears done
        end
    end
end

////////////////////////////////////////
// Read mux
////////////////////////////////////////
always_comb begin
    w_mapped = 1'b1;
    case (i_paddr)
        `FPU_REG_OPA:    o_prdata = r_opa;
        `FPU_REG_OPB:    o_prdata = r_opb;
        `FPU_REG_CTRL:   o_prdata = {{(`FPU_DATA_W-1){1'b0}}, r_op};
        `FPU_REG_STATUS: o_prdata = {{(`FPU_DATA_W-3){1'b0}}, r_overflow, r_done, r_busy};
        `FPU_REG_RESULT: o_prdata = r_result;
        default: begin
            o_prdata = '0;
            w_mapped = 1'b0;
        end
    endcase
end

assign o_pready  = 1'b1;                   // Zero wait states
assign o_pslverr = w_access && !w_mapped;

endmodule

/* hw/fpu_apb_top.sv */
`timescale 1ns/1ns
`include "fpu_params.svh"

module fpu_apb_top (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  logic [`FPU_ADDR_W-1:0]  i_paddr,
    input  logic [`FPU_DATA_W-1:0]  i_pwdata,

    output logic [`FPU_DATA_W-1:0]  o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr
);

////////////////////////////////////////
// Register block to core link
////////////////////////////////////////
fpu_op_if u_op_if ();

fpu_apb_regs u_regs (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .o_prdata   (o_prdata),
    .o_pready   (o_pready),
    .o_pslverr  (o_pslverr),
    .io_op      (u_op_if.req)
);

// Two cycle add/sub pipeline
fpu_32bit u_core (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .io_op      (u_op_if.core)
);

endmodule

/* hw/fpu_normalize.sv */
`timescale 1ns/1ns
`include "fpu_params.svh"

module fpu_normalize #(
    parameter int SIZE_DATA = `FPU_MAN_W + `FPU_GUARD_W + 1
) (
    input  logic                    i_sign,
    input  logic                    i_carry,        // Sum spilled above bit 27
    input  logic [`FPU_EXP_W-1:0]   i_exp,
    input  logic [SIZE_DATA-1:0]    i_mantissa,

    output fpu_pkg::fpu_float_s     o_result,
    output logic                    o_overflow
);

localparam int SHW = $clog2(SIZE_DATA);     // Shift count width
localparam int EWW = `FPU_EXP_W + 2;        // Signed work exponent

////////////////////////////////////////
// Leading one detect
////////////////////////////////////////
logic [SHW-1:0] w_lead_zeros;

always_comb begin
    w_lead_zeros = '0;
    // Highest set bit wins since it is seen last
    for (int i = 0; i < SIZE_DATA; i++) begin
        if (i_mantissa[i]) begin
            w_lead_zeros = SHW'(SIZE_DATA - 1 - i);
        end
    end
end

logic [SIZE_DATA-1:0] w_man_shifted;

shf_unit #(
    .LEFT_RIGHT (0),
    .SIZE_DATA  (SIZE_DATA),
    .SIZE_SHIFT (SHW)
) u_shf_norm (
    .i_shift_number (w_lead_zeros),
    .i_data         (i_mantissa),
    .o_data         (w_man_shifted)
);

////////////////////////////////////////
// Exponent adjust
////////////////////////////////////////
logic [SIZE_DATA-1:0]  w_man_norm;
logic signed [EWW-1:0] w_exp_work;

assign w_man_norm = i_carry ? {1'b1, i_mantissa[SIZE_DATA-1:1]} : w_man_shifted;

always_comb begin
    if (i_carry) begin
        w_exp_work = $signed({2'b00, i_exp}) + EWW'(1);     // Right by one
    end else begin
        w_exp_work = $signed({2'b00, i_exp})
                   - $signed({{(EWW-SHW){1'b0}}, w_lead_zeros});
    end
end

////////////////////////////////////////
// Special cases and packing
////////////////////////////////////////
always_comb begin
    o_overflow = 1'b0;
    if (!i_carry && (i_mantissa == '0)) begin
        o_result = '0;                          // Exact zero is positive
    end else if (w_exp_work >= EWW'(255)) begin
        o_result.sign = i_sign;                 // Signed infinity
        o_result.exp  = '1;
        o_result.frac = '0;
        o_overflow    = 1'b1;
    end else if (w_exp_work <= EWW'(0)) begin
        o_result.sign = i_sign;                 // Underflow to signed zero
        o_result.exp  = '0;
        o_result.frac = '0;
    end else begin
        o_result.sign = i_sign;
        o_result.exp  = w_exp_work[`FPU_EXP_W-1:0];
        o_result.frac = w_man_norm[SIZE_DATA-2:`FPU_GUARD_W];   // Truncate guard bits
    end
end

endmodule

/* hw/fpu_op_if.sv */
`timescale 1ns/1ns

interface fpu_op_if;

    // Request side, driven by the register block
    logic                   req_valid;  // One cycle pulse
    fpu_pkg::fpu_op_e       req_op;
    fpu_pkg::fpu_float_s    req_a;
    fpu_pkg::fpu_float_s    req_b;

    // Response side, driven by the core
    logic                   res_valid;  // Two cycles after req_valid
    fpu_pkg::fpu_float_s    res_data;
    logic                   res_overflow;

    modport req (
        output req_valid, req_op, req_a, req_b,
        input  res_valid, res_data, res_overflow
    );

    modport core (
        input  req_valid, req_op, req_a, req_b,
        output res_valid, res_data, res_overflow
    );

endinterface

/* hw/fpu_pkg.sv */
`include "fpu_params.svh"

package fpu_pkg;

    ////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////
    typedef enum logic {
        FPU_ADD = 1'b0,
        FPU_SUB = 1'b1
    } fpu_op_e;

    ////////////////////////////////////////
    // IEEE 754 single precision layout
    ////////////////////////////////////////
    typedef struct packed {
        logic                   sign;   // Bit 31
        logic [`FPU_EXP_W-1:0]  exp;    // Biased exponent
        logic [`FPU_MAN_W-1:0]  frac;   // Stored fraction, no hidden one
    } fpu_float_s;

endpackage

/* hw/shf_unit.sv */
`timescale 1ns/1ns

module shf_unit #(
    parameter int LEFT_RIGHT = 1,   // 1 shifts right, 0 shifts left
    parameter int SIZE_DATA  = 28,
    parameter int SIZE_SHIFT = 5
) (
    input  logic [SIZE_SHIFT-1:0]   i_shift_number,
    input  logic [SIZE_DATA-1:0]    i_data,
    output logic [SIZE_DATA-1:0]    o_data
);

// One stage per bit of the shift count
logic [SIZE_DATA-1:0] w_stage [0:SIZE_SHIFT];

assign w_stage[0] = i_data;

for (genvar k = 0; k < SIZE_SHIFT; k++) begin : g_stage
    localparam int STEP = 2 ** k;   // Weight of this count bit

    if (STEP >= SIZE_DATA) begin : g_flush
        // Whole word falls out
        assign w_stage[k+1] = i_shift_number[k] ? '0 : w_stage[k];
    end else if (LEFT_RIGHT != 0) begin : g_right
        assign w_stage[k+1] = i_shift_number[k]
                            ? {{STEP{1'b0}}, w_stage[k][SIZE_DATA-1:STEP]}
                            : w_stage[k];
    end else begin : g_left
        assign w_stage[k+1] = i_shift_number[k]
                            ? {w_stage[k][SIZE_DATA-1-STEP:0], {STEP{1'b0}}}
                            : w_stage[k];
    end
end

assign o_data = w_stage[SIZE_SHIFT];    // Zero filled result

endmodule

/* include/fpu_params.svh */
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// Float field widths
`define FPU_DATA_W      32
`define FPU_EXP_W       8
`define FPU_MAN_W       23
`define FPU_GUARD_W     4   // Low guard bits below the hidden one

// APB register map
`define FPU_ADDR_W      5
`define FPU_REG_OPA     5'h00
`define FPU_REG_OPB     5'h04
`define FPU_REG_CTRL    5'h08
`define FPU_REG_STATUS  5'h0C
`define FPU_REG_RESULT  5'h10

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the FPU APB testbench with Verilator

TOP=tb_fpu_apb
OBJ=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module "$TOP" -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

OUT=$("./$OBJ/V$TOP")
RC=$?
echo "$OUT"
if [ $RC -ne 0 ]; then
    echo "Simulation exited with status $RC"
    exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$OUT" | grep -qx "Finished with no errors"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1

/* sim/tb_fpu_apb.sv */
`timescale 1ns/1ns
`include "fpu_params.svh"

module tb_fpu_apb;

localparam int N_RANDOM = 300;
localparam int N_TESTS  = N_RANDOM + 20;            // Directed, register and random runs
localparam int WDOG_CYC = N_TESTS * 20 + 1000;

logic        clk;
logic        reset;
logic        psel, penable, pwrite;
logic [4:0]  paddr;
logic [31:0] pwdata;
logic [31:0] prdata;
logic        pready, pslverr;

typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic        sub;
    logic [31:0] res;   // RESULT as read back
    logic        ovf;   // STATUS bit 2
} op_rec_t;

op_rec_t     results_q[$];
int          errors    = 0;
int          n_pushed  = 0;
int          n_checked = 0;
logic [31:0] lfsr_state = 32'd87;

fpu_apb_top i_dut (
    .i_clk     (clk),
    .i_reset   (reset),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr)
);

always #50 clk = ~clk;  // 100 ns period

////////////////////////////////////////
// Reference model
////////////////////////////////////////
function automatic logic [32:0] fp_addsub_ref(input logic [31:0] a, input logic [31:0] b,
                                              input logic sub);
    logic        s_big, s_small;
    int          e_big, e_small, shift;
    logic [28:0] m_big, m_small, m_sum;     // Bit 28 catches the carry
    s_big   = a[31];
    s_small = b[31] ^ sub;                  // Subtract flips B
    e_big   = int'(a[30:23]);
    e_small = int'(b[30:23]);
    m_big   = (a[30:23] == 8'd0) ? 29'd0 : {2'b01, a[22:0], 4'b0000};
    m_small = (b[30:23] == 8'd0) ? 29'd0 : {2'b01, b[22:0], 4'b0000};
    // Greater magnitude leads
    if ((e_small > e_big) || ((e_small == e_big) && (m_small > m_big))) begin
        {s_big, s_small} = {s_small, s_big};
        {e_big, e_small} = {e_small, e_big};
        {m_big, m_small} = {m_small, m_big};
    end
    shift   = e_big - e_small;
    m_small = (shift >= 28) ? 29'd0 : (m_small >> shift);
    m_sum   = (s_big == s_small) ? (m_big + m_small) : (m_big - m_small);
    if (m_sum == 29'd0) begin
        return 33'd0;                       // Exact zero is +0
    end
    if (m_sum[28]) begin
        m_sum = m_sum >> 1;
        e_big = e_big + 1;
    end else begin
        while (!m_sum[27]) begin            // Leading one up to bit 27
            m_sum = m_sum << 1;
            e_big = e_big - 1;
        end
    end
    if (e_big >= 255) begin
        return {1'b1, s_big, 8'hFF, 23'd0};
    end
    if (e_big <= 0) begin
        return {1'b0, s_big, 31'd0};
    end
    return {1'b0, s_big, e_big[7:0], m_sum[26:4]};  // Truncated fraction
endfunction

////////////////////////////////////////
// Random source
////////////////////////////////////////
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        val = {val[30:0], lfsr_state[0]};   // One step per bit
    end
endtask

task automatic rand_float(output logic [31:0] f);
    logic [31:0] s, e, m;
    take_bits(1, s);
    take_bits(8, e);
    take_bits(23, m);
    f = {s[0], 8'(32'd1 + e % 32'd254), m[22:0]};  // Exponent kept in 1..254
endtask

////////////////////////////////////////
// APB access
////////////////////////////////////////
function automatic logic reg_is_mapped(input logic [4:0] addr);
    return addr inside {`FPU_REG_OPA, `FPU_REG_OPB, `FPU_REG_CTRL,
                        `FPU_REG_STATUS, `FPU_REG_RESULT};
endfunction

task automatic check_resp(input logic [4:0] addr);
    if ((pslverr !== !reg_is_mapped(addr)) || (pready !== 1'b1)) begin
        errors++;
        $display("Unexpected APB response at offset %h, time %0t: pslverr %b pready %b",
                 addr, $time, pslverr, pready);
    end
endtask

task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;    // Setup phase
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);     // Middle of the access phase
    check_resp(addr);
endtask

task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    check_resp(addr);
endtask

task automatic apb_idle();
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

////////////////////////////////////////
// Operation sequences
////////////////////////////////////////
task automatic launch_op(input logic [31:0] a, input logic [31:0] b, input logic sub);
    apb_write(`FPU_REG_OPA, a);
    apb_write(`FPU_REG_OPB, b);
    apb_write(`FPU_REG_CTRL, {30'd0, 1'b1, sub});   // Start with op bit
endtask

task automatic collect_op(input logic [31:0] a, input logic [31:0] b, input logic sub);
    logic [31:0] st;
    logic [31:0] res;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[1] && (polls < 8)) begin
        apb_read(`FPU_REG_STATUS, st);
        polls++;
    end
    if (!st[1]) begin
        errors++;
        $display("Done was never set for %h op %b %h", a, sub, b);
    end else begin
        apb_read(`FPU_REG_RESULT, res);
        results_q.push_back('{a, b, sub, res, st[2]});  // Handed to the compare process
        n_pushed++;
    end
endtask

task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic sub);
    launch_op(a, b, sub);
    collect_op(a, b, sub);
endtask

task automatic check_word(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want) begin
        errors++;
        $display("Fail %0t: %s read %h, expected %h", $time, what, got, want);
    end
endtask

// Compare against the reference model
always @(posedge clk) begin : compare_results
    op_rec_t     rec;
    logic [32:0] want;
    if (results_q.size() != 0) begin
        rec  = results_q.pop_front();
        want = fp_addsub_ref(rec.a, rec.b, rec.sub);
        if ((rec.res !== want[31:0]) || (rec.ovf !== want[32])) begin
            errors++;
            $display("Fail %0t: %h op %b %h gave %h ovf %b, expected %h ovf %b", $time,
                     rec.a, rec.sub, rec.b, rec.res, rec.ovf, want[31:0], want[32]);
        end
        n_checked++;
    end
end

initial begin : watchdog
    repeat (WDOG_CYC) @(posedge clk);
    $display("Timeout, the run did not complete within %0d cycles", WDOG_CYC);
    $display("Finished with errors");
    $finish;
end

////////////////////////////////////////
// Main sequence
////////////////////////////////////////
initial begin : main_seq
    logic [31:0] rd, fa, fb, fop;
    clk     = 1'b0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    apb_read(`FPU_REG_STATUS, rd);
    check_word(rd, 32'd0, "STATUS after reset");
    apb_read(`FPU_REG_RESULT, rd);
    check_word(rd, 32'd0, "RESULT after reset");

    // Register readback and decode errors
    apb_write(`FPU_REG_OPA, 32'h1234_5678);
    apb_write(`FPU_REG_OPB, 32'h9ABC_DEF0);
    apb_read(`FPU_REG_OPA, rd);
    check_word(rd, 32'h1234_5678, "OPA");
    apb_read(`FPU_REG_OPB, rd);
    check_word(rd, 32'h9ABC_DEF0, "OPB");
    apb_write(`FPU_REG_CTRL, 32'd1);            // Op bit only, no launch
    apb_read(`FPU_REG_CTRL, rd);
    check_word(rd, 32'd1, "CTRL");
    apb_read(`FPU_REG_STATUS, rd);
    check_word(rd, 32'd0, "STATUS without start");
    apb_read(5'h14, rd);                        // Unmapped, expects pslverr
    apb_write(5'h1C, 32'hDEAD_BEEF);

    // Busy right after start, done three cycles after the start access
    launch_op(32'h3F80_0000, 32'h3F80_0000, 1'b0);
    apb_read(`FPU_REG_STATUS, rd);
    check_word(rd & 32'h3, 32'h1, "STATUS busy after start");
    collect_op(32'h3F80_0000, 32'h3F80_0000, 1'b0);
    launch_op(32'h3F80_0000, 32'h3F80_0000, 1'b0);
    apb_idle();
    apb_read(`FPU_REG_STATUS, rd);
    check_word(rd & 32'h3, 32'h2, "STATUS done at third cycle");
    collect_op(32'h3F80_0000, 32'h3F80_0000, 1'b0);

    // Second start lands while busy and must be dropped
    launch_op(32'h3FC0_0000, 32'h3E80_0000, 1'b0);
    apb_write(`FPU_REG_CTRL, 32'd3);
    collect_op(32'h3FC0_0000, 32'h3E80_0000, 1'b0);

    run_op(32'h3F80_0000, 32'h3F80_0000, 1'b0);    // 1.0 + 1.0
    run_op(32'h3FC0_0000, 32'h3E80_0000, 1'b1);    // 1.5 - 0.25
    run_op(32'h3FA0_0000, 32'h3FE0_0000, 1'b1);    // Equal exponents, smaller A
    run_op(32'h4049_0FDB, 32'h4049_0FDB, 1'b1);    // x - x
    run_op(32'h5000_0000, 32'h3F80_0000, 1'b0);    // Difference 33
    run_op(32'h3F80_0000, 32'h5000_0000, 1'b1);
    run_op(32'h4D80_0000, 32'h3F80_0000, 1'b1);    // Difference exactly 28
    run_op(32'h4D00_0000, 32'h3F80_0000, 1'b0);    // 27 still reaches guard bits
    run_op(32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0);    // Overflow to +inf
    run_op(32'hFF7F_FFFF, 32'hFF7F_FFFF, 1'b0);
    run_op(32'h00C0_0000, 32'h0080_0000, 1'b1);    // Cancels below exponent 1
    run_op(32'h0012_3456, 32'h3F80_0000, 1'b0);    // Zero exponent acts as zero
    run_op(32'h3F80_0000, 32'h0040_0000, 1'b1);

    for (int n = 0; n < N_RANDOM; n++) begin
        rand_float(fa);
        rand_float(fb);
        take_bits(1, fop);
        run_op(fa, fb, fop[0]);
    end
    apb_idle();

    while (n_checked != n_pushed) @(posedge clk);
    $display("Operations checked: %0d, errors: %0d", n_checked, errors);
    if (errors == 0) begin
        $display("Finished with no errors");
    end else begin
        $display("Finished with errors");
    end
    $finish;
end

endmodule
